//--- verilog.f
+incdir+tb
rtl/rv_mem_pkg.sv
rtl/mem_bus_if.sv
rtl/mem_stage.sv
rtl/load_align.sv
rtl/data_ram.sv
rtl/wb_stage.sv
rtl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_mem_subsys -f verilog.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

# A crash without a verdict counts as a failure
./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Simulation finished: FAIL" >> sim.log
cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
  && { echo "Result: FAIL"; exit 1; } \
  || { echo "Result: PASS"; exit 0; }

//--- tb/mem_ref_model.svh
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// One instruction as it leaves execute
typedef struct packed {
  logic [63:0] alu_result;
  logic [63:0] rs2_data;
  logic [63:0] pc;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic        reg_write;
  logic        mem_read;
  logic        mem_write;
  logic        trap;
  logic [3:0]  trap_cause;
  logic [11:0] csr_addr;
  logic [63:0] csr_wdata;
  logic        csr_write;
} instr_t;

logic [7:0]  ref_mem  [rv_mem_pkg::RAM_BYTES];
logic [63:0] ref_regs [32];

function automatic void reset_model();
  foreach (ref_mem[i]) ref_mem[i] = 8'h00;
  foreach (ref_regs[i]) ref_regs[i] = 64'd0;
endfunction

function automatic int access_bytes(input logic [2:0] f3);
  return 1 << f3[1:0];
endfunction

function automatic bit misaligned(input logic [63:0] addr, input logic [2:0] f3);
  return (int'(addr[2:0]) % access_bytes(f3)) != 0;
endfunction

function automatic bit in_ram(input logic [63:0] addr);
  return addr < 64'(rv_mem_pkg::RAM_BYTES);
endfunction

function automatic bit is_mem(input instr_t in);
  return in.mem_read || in.mem_write;
endfunction

function automatic bit issues_request(input instr_t in);
  return is_mem(in) && !in.trap && !misaligned(in.alu_result, in.funct3);
endfunction

function automatic bit raises_exception(input instr_t in);
  return in.trap || (is_mem(in) && (misaligned(in.alu_result, in.funct3) ||
                                    !in_ram(in.alu_result)));
endfunction

// Trap first, then alignment, then range
function automatic logic [3:0] cause_of(input instr_t in);
  if (in.trap) return in.trap_cause;
  if (!is_mem(in)) return rv_mem_pkg::EXC_NONE;
  if (misaligned(in.alu_result, in.funct3)) begin
    return in.mem_read ? rv_mem_pkg::EXC_LOAD_MISALIGNED : rv_mem_pkg::EXC_STORE_MISALIGNED;
  end
  if (!in_ram(in.alu_result)) begin
    return in.mem_read ? rv_mem_pkg::EXC_LOAD_FAULT : rv_mem_pkg::EXC_STORE_FAULT;
  end
  return rv_mem_pkg::EXC_NONE;
endfunction

// Little endian gather, then sign or zero fill
function automatic logic [63:0] read_mem_bytes(input logic [63:0] addr, input logic [2:0] f3);
  logic [63:0] raw;
  int          n;
  raw = 64'd0;
  n   = access_bytes(f3);
  for (int i = 0; i < n; i++) raw[8*i +: 8] = ref_mem[int'(addr[9:0]) + i];
  if (!f3[2]) begin
    for (int b = 8 * n; b < 64; b++) raw[b] = raw[8*n-1];
  end
  return raw;
endfunction

function automatic void write_mem_bytes(input logic [63:0] addr, input logic [2:0] f3,
                                        input logic [63:0] data);
  for (int i = 0; i < access_bytes(f3); i++) ref_mem[int'(addr[9:0]) + i] = data[8*i +: 8];
endfunction

function automatic void retire_instr(input instr_t in);
  if (raises_exception(in)) return;
  if (in.mem_write && !in.mem_read) write_mem_bytes(in.alu_result, in.funct3, in.rs2_data);
  if (in.reg_write && in.rd != 5'd0) begin
    ref_regs[in.rd] = in.mem_read ? read_mem_bytes(in.alu_result, in.funct3) : in.alu_result;
  end
endfunction

`endif

//--- tb/tb_mem_subsys.sv
module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int STALL_TIMEOUT = 20;

  logic        clk;
  logic        resetn;
  logic        flush;
  logic [63:0] alu_result;
  logic [63:0] rs2_data;
  logic [63:0] pc_in;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic        reg_write_enable;
  logic        mem_read;
  logic        mem_write;
  logic        trap_in;
  logic [3:0]  trap_cause_in;
  logic [11:0] csr_addr;
  logic [63:0] csr_wdata;
  logic        csr_write;
  logic [4:0]  rs_addr;
  logic        mem_stall;
  logic [63:0] pc_out;
  logic        exception_occurred;
  logic [63:0] exception_pc;
  logic [3:0]  exception_cause;
  logic [11:0] csr_addr_out;
  logic [63:0] csr_wdata_out;
  logic        csr_write_out;
  logic [63:0] rs_data;
  logic        bus_read_req;
  logic        bus_write_req;
  logic [63:0] bus_addr;

  int checks;
  int errors;
  int test_checks;
  int test_errors;

  `include "mem_ref_model.svh"

  mem_subsys_top mem_subsys_top_inst (
    .clk(clk), .resetn(resetn), .flush(flush),
    .alu_result(alu_result), .rs2_data(rs2_data), .pc_in(pc_in),
    .rd(rd), .funct3(funct3), .reg_write_enable(reg_write_enable),
    .mem_read(mem_read), .mem_write(mem_write),
    .trap_in(trap_in), .trap_cause_in(trap_cause_in),
    .csr_addr(csr_addr), .csr_wdata(csr_wdata), .csr_write(csr_write),
    .rs_addr(rs_addr), .mem_stall(mem_stall), .pc_out(pc_out),
    .exception_occurred(exception_occurred), .exception_pc(exception_pc),
    .exception_cause(exception_cause), .csr_addr_out(csr_addr_out),
    .csr_wdata_out(csr_wdata_out), .csr_write_out(csr_write_out),
    .rs_data(rs_data), .bus_read_req(bus_read_req),
    .bus_write_req(bus_write_req), .bus_addr(bus_addr)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    test_checks++;
    assert (act === exp) else begin
      $display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    test_checks++;
    assert (cond) else begin
      $display("ERROR %s at %0t", what, $time);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  function automatic logic [63:0] random_dword();
    return {$urandom(), $urandom()};
  endfunction

  function automatic int aligned_offset(input logic [2:0] f3);
    return int'($urandom_range(0, 7)) & ~(access_bytes(f3) - 1);
  endfunction

  task automatic drive_instr(input instr_t in);
    alu_result       <= in.alu_result;
    rs2_data         <= in.rs2_data;
    pc_in            <= in.pc;
    rd               <= in.rd;
    funct3           <= in.funct3;
    reg_write_enable <= in.reg_write;
    mem_read         <= in.mem_read;
    mem_write        <= in.mem_write;
    trap_in          <= in.trap;
    trap_cause_in    <= in.trap_cause;
    csr_addr         <= in.csr_addr;
    csr_wdata        <= in.csr_wdata;
    csr_write        <= in.csr_write;
  endtask

  // Called at a falling edge
  task automatic wait_stall_low(output int cycles);
    cycles = 0;
    while (mem_stall && cycles < STALL_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (mem_stall) begin
      $display("Timeout: mem_stall still high after %0d cycles at %0t", STALL_TIMEOUT, $time);
      $display("Simulation finished: FAIL");
      $finish;
    end
  endtask

  // Hand one instruction to the stage, then a bubble
  task automatic enter_stage(input instr_t in);
    int cycles;
    @(posedge clk);
    drive_instr(in);
    @(negedge clk);
    wait_stall_low(cycles);  // held while the stage is busy
    @(posedge clk);
    drive_instr('0);
    @(negedge clk);
  endtask

  task automatic check_register(input logic [4:0] r);
    @(posedge clk);
    rs_addr <= r;
    @(posedge clk);  // write lands on this edge
    @(negedge clk);
    check_value($sformatf("rs_data x%0d", r), ref_regs[r], rs_data);
  endtask

  task automatic run_instr(input instr_t in);
    int cycles;
    bit exp_req;
    bit exp_exc;
    exp_req = issues_request(in);
    exp_exc = raises_exception(in);
    enter_stage(in);
    check_value("bus_read_req", 64'(exp_req && in.mem_read), 64'(bus_read_req));
    check_value("bus_write_req", 64'(exp_req && !in.mem_read), 64'(bus_write_req));
    if (exp_req) check_value("bus_addr", in.alu_result, bus_addr);
    wait_stall_low(cycles);
    check_value("mem_stall cycles", exp_req ? 64'(rv_mem_pkg::RAM_LATENCY) : 64'd0, 64'(cycles));
    // Completion cycle
    check_value("exception_occurred", 64'(exp_exc), 64'(exception_occurred));
    if (exp_exc) begin
      check_value("exception_cause", 64'(cause_of(in)), 64'(exception_cause));
      check_value("exception_pc", in.pc, exception_pc);
    end
    check_value("pc_out", in.pc, pc_out);
    check_value("csr_write_out", 64'(in.csr_write), 64'(csr_write_out));
    check_value("csr_addr_out", 64'(in.csr_addr), 64'(csr_addr_out));
    check_value("csr_wdata_out", in.csr_wdata, csr_wdata_out);
    retire_instr(in);
    check_register(in.rd);
  endtask

  // Flush in the last counted cycle of the load
  task automatic flush_load(input instr_t in);
    enter_stage(in);
    check_true(bus_read_req == 1'b1, "load request missing before the flush");
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check_value("bus_read_req", 64'd0, 64'(bus_read_req));
    check_value("bus_write_req", 64'd0, 64'(bus_write_req));
    check_value("mem_stall", 64'd0, 64'(mem_stall));
    check_register(in.rd);
  endtask

  initial begin
    instr_t in;
    int     base;
    void'($urandom(36));
    clk     = 1'b0;
    resetn  = 1'b0;
    flush   = 1'b0;
    rs_addr = 5'd0;
    drive_instr('0);
    reset_model();
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;

    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    check_value("bus_read_req", 64'd0, 64'(bus_read_req));
    check_value("bus_write_req", 64'd0, 64'(bus_write_req));
    check_value("mem_stall", 64'd0, 64'(mem_stall));
    check_value("exception_occurred", 64'd0, 64'(exception_occurred));
    check_value("csr_write_out", 64'd0, 64'(csr_write_out));
    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      rs_addr <= 5'(r);
      @(negedge clk);
      check_value($sformatf("rs_data x%0d", r), 64'd0, rs_data);
    end
    report_test("reset state");

    repeat (20) begin
      in            = '0;
      in.alu_result = random_dword();
      in.pc         = random_dword() & ~64'h3;
      in.rd         = 5'($urandom_range(0, 31));  // x0 included
      in.reg_write  = 1'b1;
      run_instr(in);
    end
    report_test("alu write-back");

    repeat (8) begin
      base          = int'($urandom_range(0, 127)) * 8;
      in            = '0;
      in.funct3     = 3'($urandom_range(0, 3));
      in.alu_result = 64'(base + aligned_offset(in.funct3));
      in.rs2_data   = random_dword();
      in.pc         = random_dword() & ~64'h3;
      in.mem_write  = 1'b1;
      run_instr(in);
      for (int f = 0; f < 7; f++) begin
        in            = '0;
        in.funct3     = 3'(f);
        in.alu_result = 64'(base + aligned_offset(in.funct3));
        in.rd         = 5'($urandom_range(1, 31));
        in.reg_write  = 1'b1;
        in.mem_read   = 1'b1;
        run_instr(in);
      end
    end
    report_test("stores and loads");

    repeat (16) begin
      in           = '0;
      in.pc        = random_dword() & ~64'h3;
      in.rd        = 5'($urandom_range(1, 31));
      in.mem_read  = 1'($urandom_range(0, 1));
      in.mem_write = !in.mem_read;
      in.reg_write = in.mem_read;
      in.rs2_data  = random_dword();
      if ($urandom_range(0, 1) == 1) begin
        in.funct3     = 3'($urandom_range(1, 3));  // odd address below
        in.alu_result = 64'(int'($urandom_range(0, 127)) * 8 + 1 + 2 * int'($urandom_range(0, 2)));
      end else begin
        in.funct3     = 3'($urandom_range(0, 3));
        in.alu_result = (random_dword() | 64'h400) & ~64'h7;
      end
      run_instr(in);
    end
    report_test("misaligned and out of range");

    repeat (12) begin
      in            = '0;
      in.alu_result = random_dword();
      in.pc         = random_dword() & ~64'h3;
      in.rd         = 5'($urandom_range(1, 31));
      in.reg_write  = 1'b1;
      in.mem_read   = 1'($urandom_range(0, 1));
      in.trap       = 1'($urandom_range(0, 3) != 0);
      in.trap_cause = 4'($urandom_range(0, 15));
      in.csr_addr   = 12'($urandom_range(0, 4095));
      in.csr_wdata  = random_dword();
      in.csr_write  = 1'($urandom_range(0, 1));
      run_instr(in);
    end
    report_test("traps and csr");

    repeat (4) begin
      in            = '0;
      in.funct3     = 3'($urandom_range(0, 6));
      in.alu_result = 64'(int'($urandom_range(0, 127)) * 8 + aligned_offset(in.funct3));
      in.pc         = random_dword() & ~64'h3;
      in.rd         = 5'($urandom_range(1, 31));
      in.reg_write  = 1'b1;
      in.mem_read   = 1'b1;
      flush_load(in);
      run_instr(in);  // same load again, unflushed
    end
    report_test("flush");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/mem_subsys_top.sv
module mem_subsys_top (
  input  logic              clk,
  input  logic              resetn,
  input  logic              flush,
  input  rv_mem_pkg::xlen_t alu_result,
  input  rv_mem_pkg::xlen_t rs2_data,
  input  rv_mem_pkg::xlen_t pc_in,
  input  logic [4:0]        rd,
  input  logic [2:0]        funct3,
  input  logic              reg_write_enable,
  input  logic              mem_read,
  input  logic              mem_write,
  input  logic              trap_in,
  input  logic [3:0]        trap_cause_in,
  input  logic [11:0]       csr_addr,
  input  rv_mem_pkg::xlen_t csr_wdata,
  input  logic              csr_write,
  input  logic [4:0]        rs_addr,
  output logic              mem_stall,
  output rv_mem_pkg::xlen_t pc_out,
  output logic              exception_occurred,
  output rv_mem_pkg::xlen_t exception_pc,
  output logic [3:0]        exception_cause,
  output logic [11:0]       csr_addr_out,
  output rv_mem_pkg::xlen_t csr_wdata_out,
  output logic              csr_write_out,
  output rv_mem_pkg::xlen_t rs_data,
  output logic              bus_read_req,
  output logic              bus_write_req,
  output rv_mem_pkg::xlen_t bus_addr
);

  logic              wb_valid;
  logic [4:0]        wb_rd;
  logic              wb_reg_write;
  rv_mem_pkg::xlen_t wb_data;
  rv_mem_pkg::xlen_t load_data;
  logic [2:0]        stage_funct3;

  mem_bus_if bus ();

  mem_stage mem_stage_inst (
    .clk                (clk),
    .resetn             (resetn),
    .flush              (flush),
    .alu_result         (alu_result),
    .rs2_data           (rs2_data),
    .pc_in              (pc_in),
    .rd                 (rd),
    .funct3             (funct3),
    .reg_write_enable   (reg_write_enable),
    .mem_read           (mem_read),
    .mem_write          (mem_write),
    .trap_in            (trap_in),
    .trap_cause_in      (trap_cause_in),
    .csr_addr           (csr_addr),
    .csr_wdata          (csr_wdata),
    .csr_write          (csr_write),
    .load_data          (load_data),
    .bus                (bus.master),
    .mem_stall          (mem_stall),
    .wb_valid           (wb_valid),
    .rd_out             (wb_rd),
    .reg_write_out      (wb_reg_write),
    .wb_data            (wb_data),
    .pc_out             (pc_out),
    .funct3_out         (stage_funct3),
    .exception_occurred (exception_occurred),
    .exception_pc       (exception_pc),
    .exception_cause    (exception_cause),
    .csr_addr_out       (csr_addr_out),
    .csr_wdata_out      (csr_wdata_out),
    .csr_write_out      (csr_write_out)
  );

  load_align load_align_inst (
    .bus       (bus.monitor),
    .funct3    (stage_funct3),
    .load_data (load_data)
  );

  data_ram data_ram_inst (
    .clk    (clk),
    .resetn (resetn),
    .flush  (flush),
    .bus    (bus.slave)
  );

  wb_stage wb_stage_inst (
    .clk       (clk),
    .resetn    (resetn),
    .wb_valid  (wb_valid),
    .rd        (wb_rd),
    .reg_write (wb_reg_write),
    .wb_data   (wb_data),
    .rs_addr   (rs_addr),
    .rs_data   (rs_data)
  );

  // Bus observation
  assign bus_read_req  = bus.read_req;
  assign bus_write_req = bus.write_req;
  assign bus_addr      = bus.addr;

endmodule

//--- rtl/wb_stage.sv
module wb_stage (
  input  logic              clk,
  input  logic              resetn,
  input  logic              wb_valid,
  input  logic [4:0]        rd,
  input  logic              reg_write,
  input  rv_mem_pkg::xlen_t wb_data,
  input  logic [4:0]        rs_addr,
  output rv_mem_pkg::xlen_t rs_data
);

  logic              valid_q;
  logic              reg_write_q;
  logic [4:0]        rd_q;
  rv_mem_pkg::xlen_t data_q;

  rv_mem_pkg::xlen_t regs [rv_mem_pkg::NUM_REGS];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      valid_q     <= 1'b0;
      reg_write_q <= 1'b0;
    end else begin
      valid_q     <= wb_valid;
      reg_write_q <= reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_valid) begin
      rd_q   <= rd;
      data_q <= wb_data;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < rv_mem_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (valid_q && reg_write_q && rd_q != 5'd0) begin
      regs[rd_q] <= data_q;
    end
  end

  // x0 hardwired to zero
  assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];

endmodule

//--- rtl/data_ram.sv
module data_ram (
  input logic      clk,
  input logic      resetn,
  input logic      flush,
  mem_bus_if.slave bus
);

  rv_mem_pkg::xlen_t mem [rv_mem_pkg::RAM_WORDS];

  rv_mem_pkg::lat_cnt_t                 cnt;
  logic                                 ready_q;
  logic                                 error_q;
  logic                                 req;
  logic                                 in_range;
  logic                                 done;
  logic [rv_mem_pkg::RAM_ADDR_W-4:0]    word_idx;
  logic [2:0]                           offset;
  logic [7:0]                           size_mask;
  logic [7:0]                           byte_en;
  rv_mem_pkg::xlen_t                    wdata_sh;

  assign req      = bus.read_req || bus.write_req;
  assign in_range = bus.addr < rv_mem_pkg::xlen_t'(rv_mem_pkg::RAM_BYTES);
  assign word_idx = bus.addr[rv_mem_pkg::RAM_ADDR_W-1:3];
  assign offset   = bus.addr[2:0];

  // Last counted cycle of a pending request
  assign done = req && !ready_q && !error_q &&
                (cnt == rv_mem_pkg::lat_cnt_t'(rv_mem_pkg::RAM_LATENCY - 1));

  always_comb begin
    case (bus.size)
      rv_mem_pkg::BYTE: size_mask = 8'h01;
      rv_mem_pkg::HALF: size_mask = 8'h03;
      rv_mem_pkg::WORD: size_mask = 8'h0f;
      default:          size_mask = 8'hff;
    endcase
  end

  assign byte_en  = size_mask << offset;
  assign wdata_sh = bus.wdata << {offset, 3'b000};

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      cnt     <= '0;
      ready_q <= 1'b0;
      error_q <= 1'b0;
      for (int i = 0; i < rv_mem_pkg::RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (flush) begin
      cnt     <= '0;  // Pending access dropped
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= done && in_range;
      error_q <= done && !in_range;
      if (!req || done || ready_q || error_q) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + rv_mem_pkg::lat_cnt_t'(1);
      end
      if (done && in_range && bus.write_req) begin
        for (int b = 0; b < 8; b++) begin
          if (byte_en[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_sh[8*b +: 8];
          end
        end
      end
    end
  end

  assign bus.rdata = mem[word_idx];  // Whole aligned word
  assign bus.ready = ready_q;
  assign bus.error = error_q;

endmodule

//--- rtl/load_align.sv
module load_align (
  mem_bus_if.monitor        bus,
  input  logic [2:0]        funct3,
  output rv_mem_pkg::xlen_t load_data
);

  rv_mem_pkg::xlen_t shifted;

  // Addressed byte down to lane 0
  assign shifted = bus.rdata >> {bus.addr[2:0], 3'b000};

  always_comb begin
    case (funct3)
      3'd0: begin  // LB
        load_data = {{(rv_mem_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      3'd1: begin  // LH
        load_data = {{(rv_mem_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      3'd2: begin  // LW
        load_data = {{(rv_mem_pkg::XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      3'd4: begin  // LBU
        load_data = {{(rv_mem_pkg::XLEN-8){1'b0}}, shifted[7:0]};
      end
      3'd5: begin  // LHU
        load_data = {{(rv_mem_pkg::XLEN-16){1'b0}}, shifted[15:0]};
      end
      3'd6: begin  // LWU
        load_data = {{(rv_mem_pkg::XLEN-32){1'b0}}, shifted[31:0]};
      end
      default: begin
        load_data = shifted;  // LD
      end
    endcase
  end

endmodule

//--- rtl/mem_stage.sv
module mem_stage (
  input  logic               clk,
  input  logic               resetn,
  input  logic               flush,
  input  rv_mem_pkg::xlen_t  alu_result,
  input  rv_mem_pkg::xlen_t  rs2_data,
  input  rv_mem_pkg::xlen_t  pc_in,
  input  logic [4:0]         rd,
  input  logic [2:0]         funct3,
  input  logic               reg_write_enable,
  input  logic               mem_read,
  input  logic               mem_write,
  input  logic               trap_in,
  input  logic [3:0]         trap_cause_in,
  input  logic [11:0]        csr_addr,
  input  rv_mem_pkg::xlen_t  csr_wdata,
  input  logic               csr_write,
  input  rv_mem_pkg::xlen_t  load_data,
  mem_bus_if.master          bus,
  output logic               mem_stall,
  output logic               wb_valid,
  output logic [4:0]         rd_out,
  output logic               reg_write_out,
  output rv_mem_pkg::xlen_t  wb_data,
  output rv_mem_pkg::xlen_t  pc_out,
  output logic [2:0]         funct3_out,
  output logic               exception_occurred,
  output rv_mem_pkg::xlen_t  exception_pc,
  output logic [3:0]         exception_cause,
  output logic [11:0]        csr_addr_out,
  output rv_mem_pkg::xlen_t  csr_wdata_out,
  output logic               csr_write_out
);

  rv_mem_pkg::access_size_e size_in;
  logic                     misaligned_in;
  logic                     issue_in;

  logic valid_q;
  logic read_req_q;
  logic write_req_q;
  logic mem_read_q;
  logic reg_write_q;
  logic trap_q;
  logic misal_q;
  logic csr_write_q;

  rv_mem_pkg::xlen_t        addr_q;
  rv_mem_pkg::xlen_t        wdata_q;
  rv_mem_pkg::xlen_t        pc_q;
  rv_mem_pkg::xlen_t        csr_wdata_q;
  rv_mem_pkg::access_size_e size_q;
  logic [4:0]               rd_q;
  logic [2:0]               funct3_q;
  logic [3:0]               trap_cause_q;
  logic [11:0]              csr_addr_q;

  logic bus_fault;
  logic exc_any;

  assign size_in = rv_mem_pkg::access_size_e'({1'b0, funct3[1:0]});

  always_comb begin
    unique case (size_in)
      rv_mem_pkg::HALF:   misaligned_in = alu_result[0];
      rv_mem_pkg::WORD:   misaligned_in = |alu_result[1:0];
      rv_mem_pkg::DOUBLE: misaligned_in = |alu_result[2:0];
      default:            misaligned_in = 1'b0;
    endcase
  end

  // Traps and misaligned accesses never reach the bus
  assign issue_in = (mem_read || mem_write) && !trap_in && !misaligned_in;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      valid_q     <= 1'b0;
      read_req_q  <= 1'b0;
      write_req_q <= 1'b0;
      mem_read_q  <= 1'b0;
      reg_write_q <= 1'b0;
      trap_q      <= 1'b0;
      misal_q     <= 1'b0;
      csr_write_q <= 1'b0;
    end else if (flush) begin
      valid_q     <= 1'b0;
      read_req_q  <= 1'b0;
      write_req_q <= 1'b0;
      mem_read_q  <= 1'b0;
      reg_write_q <= 1'b0;
      trap_q      <= 1'b0;
      misal_q     <= 1'b0;
      csr_write_q <= 1'b0;
    end else if (!mem_stall) begin
      valid_q     <= 1'b1;
      read_req_q  <= issue_in && mem_read;
      write_req_q <= issue_in && !mem_read;  // Load wins if both set
      mem_read_q  <= mem_read;
      reg_write_q <= reg_write_enable;
      trap_q      <= trap_in;
      misal_q     <= (mem_read || mem_write) && misaligned_in;
      csr_write_q <= csr_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall) begin
      addr_q       <= alu_result;
      wdata_q      <= rs2_data;
      pc_q         <= pc_in;
      size_q       <= size_in;
      rd_q         <= rd;
      funct3_q     <= funct3;
      trap_cause_q <= trap_cause_in;
      csr_addr_q   <= csr_addr;
      csr_wdata_q  <= csr_wdata;
    end
  end

  assign bus.addr      = addr_q;
  assign bus.wdata     = wdata_q;
  assign bus.size      = size_q;
  assign bus.read_req  = read_req_q;
  assign bus.write_req = write_req_q;

  assign mem_stall = (read_req_q || write_req_q) && !bus.ready && !bus.error;
  assign wb_valid  = valid_q && !mem_stall && !flush;

  assign bus_fault = (read_req_q || write_req_q) && bus.error;
  assign exc_any   = trap_q || misal_q || bus_fault;

  // Trap over misaligned over bus fault
  always_comb begin
    if (trap_q) begin
      exception_cause = trap_cause_q;
    end else if (misal_q) begin
      exception_cause = mem_read_q ? rv_mem_pkg::EXC_LOAD_MISALIGNED
                                   : rv_mem_pkg::EXC_STORE_MISALIGNED;
    end else if (bus_fault) begin
      exception_cause = read_req_q ? rv_mem_pkg::EXC_LOAD_FAULT
                                   : rv_mem_pkg::EXC_STORE_FAULT;
    end else begin
      exception_cause = rv_mem_pkg::EXC_NONE;
    end
  end

  assign exception_occurred = wb_valid && exc_any;
  assign exception_pc       = pc_q;

  assign rd_out        = rd_q;
  assign reg_write_out = wb_valid && reg_write_q && !exc_any;
  assign wb_data       = mem_read_q ? load_data : addr_q;
  assign pc_out        = pc_q;
  assign funct3_out    = funct3_q;

  assign csr_addr_out  = csr_addr_q;
  assign csr_wdata_out = csr_wdata_q;
  assign csr_write_out = wb_valid && csr_write_q;

endmodule

//--- rtl/mem_bus_if.sv
interface mem_bus_if ();

  rv_mem_pkg::xlen_t        addr;
  rv_mem_pkg::xlen_t        wdata;
  logic                     read_req;
  logic                     write_req;
  rv_mem_pkg::access_size_e size;
  rv_mem_pkg::xlen_t        rdata;
  logic                     ready;  // One-cycle pulse
  logic                     error;  // Replaces ready when out of range

  modport master (
    output addr,
    output wdata,
    output read_req,
    output write_req,
    output size,
    input  rdata,
    input  ready,
    input  error
  );

  modport slave (
    input  addr,
    input  wdata,
    input  read_req,
    input  write_req,
    input  size,
    output rdata,
    output ready,
    output error
  );

  modport monitor (
    input addr,
    input size,
    input rdata
  );

endinterface

//--- rtl/rv_mem_pkg.sv
package rv_mem_pkg;

  localparam int unsigned XLEN = 64;

  // Data RAM geometry
  localparam int unsigned RAM_BYTES  = 1024;
  localparam int unsigned RAM_WORDS  = RAM_BYTES / (XLEN / 8);
  localparam int unsigned RAM_ADDR_W = $clog2(RAM_BYTES);

  // Request to ready/error pulse, in cycles
  localparam int unsigned RAM_LATENCY = 2;
  localparam int unsigned LAT_CNT_W   = $clog2(RAM_LATENCY + 1);

  localparam int unsigned NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

  // Same encoding as funct3[1:0] of loads and stores
  typedef enum logic [2:0] {
    BYTE   = 3'd0,
    HALF   = 3'd1,
    WORD   = 3'd2,
    DOUBLE = 3'd3
  } access_size_e;

  // Subset of the RISC-V mcause exception codes
  typedef enum logic [3:0] {
    EXC_NONE             = 4'd0,
    EXC_LOAD_MISALIGNED  = 4'd4,
    EXC_LOAD_FAULT       = 4'd5,
    EXC_STORE_MISALIGNED = 4'd6,
    EXC_STORE_FAULT      = 4'd7
  } exc_cause_e;

endpackage
